// ==== hdl/decodeStage.sv ====
//################################################
// control decode, register file, immediate and
// branch target, ID/EX register
//################################################
`timescale 1ns/1ps

module decodeStage (
    input  logic clk,
    input  logic rstN,
    input  logic run,
    input  logic stall,
    input  logic branchTaken,
    input  mipsPkg::instrT ifidInstr,
    input  mipsPkg::wordT ifidPcNext,
    input  logic wbValid,
    input  mipsPkg::regAddrT wbAddr,
    input  mipsPkg::wordT wbData,
    output logic halting,
    output logic idexRegWr,
    output logic idexMemRd,
    output logic idexMemWr,
    output logic idexMemToReg,
    output logic idexBranchEq,
    output logic idexBranchNe,
    output logic idexAluSrcImm,
    output logic idexHalt,
    output mipsPkg::aluOpT idexAluOp,
    output mipsPkg::wordT idexRsData,
    output mipsPkg::wordT idexRtData,
    output mipsPkg::wordT idexImm,
    output mipsPkg::wordT idexBranchTarget,
    output mipsPkg::regAddrT idexRs,
    output mipsPkg::regAddrT idexRt,
    output mipsPkg::regAddrT idexDst
);
    import mipsPkg::*;

    logic regWr, memRd, memWr, memToReg, branchEq, branchNe, aluSrcImm, haltNow;
    logic haltedQ;
    logic bubble;
    aluOpT aluOp;
    regAddrT rs, rt;
    wordT rsData, rtData, imm;
    wordT regs [32];

    assign rs = ifidInstr.r.rs;
    assign rt = ifidInstr.r.rt;
    assign imm = {{16{ifidInstr.i.imm16[15]}}, ifidInstr.i.imm16};
    assign bubble = !run || stall || branchTaken;

    always_comb begin
        regWr = 1'b0;
        memRd = 1'b0;
        memWr = 1'b0;
        memToReg = 1'b0;
        branchEq = 1'b0;
        branchNe = 1'b0;
        aluSrcImm = 1'b0;
        haltNow = 1'b0;
        aluOp = aluAdd;
        case (ifidInstr.i.opcode)
            opRtype: begin
                regWr = 1'b1;
                case (ifidInstr.r.funct)
                    fnAdd: aluOp = aluAdd;
                    fnSub: aluOp = aluSub;
                    fnAnd: aluOp = aluAnd;
                    fnOr: aluOp = aluOr;
                    fnSlt: aluOp = aluSlt;
                    // unknown funct, including the all-zero no-op
                    default: regWr = 1'b0;
                endcase
            end
            opAddi: begin
                regWr = 1'b1;
                aluSrcImm = 1'b1;
            end
            opLw: begin
                regWr = 1'b1;
                memRd = 1'b1;
                memToReg = 1'b1;
                aluSrcImm = 1'b1;
            end
            opSw: begin
                memWr = 1'b1;
                aluSrcImm = 1'b1;
            end
            opBeq: branchEq = 1'b1;
            opBne: branchNe = 1'b1;
            opHalt: haltNow = 1'b1;
            default: ;
        endcase
    end

    // write-through so a same-cycle writeback is seen
    assign rsData = (rs == '0) ? '0 : (wbValid && wbAddr == rs) ? wbData : regs[rs];
    assign rtData = (rt == '0) ? '0 : (wbValid && wbAddr == rt) ? wbData : regs[rt];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbValid && wbAddr != '0) begin
            regs[wbAddr] <= wbData;
        end
    end

    // PC stays frozen once the halt has moved on
    always_ff @(posedge clk) begin
        if (!rstN || !run) begin
            haltedQ <= 1'b0;
        end else if (haltNow && !stall && !branchTaken) begin
            haltedQ <= 1'b1;
        end
    end

    assign halting = haltNow || haltedQ;

    always_ff @(posedge clk) begin
        if (!rstN || bubble) begin
            idexRegWr <= 1'b0;
            idexMemRd <= 1'b0;
            idexMemWr <= 1'b0;
            idexMemToReg <= 1'b0;
            idexBranchEq <= 1'b0;
            idexBranchNe <= 1'b0;
            idexAluSrcImm <= 1'b0;
            idexHalt <= 1'b0;
            idexAluOp <= aluAdd;
        end else begin
            idexRegWr <= regWr;
            idexMemRd <= memRd;
            idexMemWr <= memWr;
            idexMemToReg <= memToReg;
            idexBranchEq <= branchEq;
            idexBranchNe <= branchNe;
            idexAluSrcImm <= aluSrcImm;
            idexHalt <= haltNow;
            idexAluOp <= aluOp;
        end
    end

    always_ff @(posedge clk) begin
        idexRsData <= rsData;
        idexRtData <= rtData;
        idexImm <= imm;
        idexBranchTarget <= ifidPcNext + (imm << 2);
        idexRs <= rs;
        idexRt <= rt;
        idexDst <= (ifidInstr.i.opcode == opRtype) ? ifidInstr.r.rd : rt;
    end

endmodule

// ==== hdl/executeStage.sv ====
//################################################
// forwarding muxes, ALU, branch decision and
// EX/MEM register
//################################################
`timescale 1ns/1ps

module executeStage (
    input  logic clk,
    input  logic rstN,
    input  logic run,
    input  logic idexRegWr,
    input  logic idexMemRd,
    input  logic idexMemWr,
    input  logic idexMemToReg,
    input  logic idexBranchEq,
    input  logic idexBranchNe,
    input  logic idexAluSrcImm,
    input  logic idexHalt,
    input  mipsPkg::aluOpT idexAluOp,
    input  mipsPkg::wordT idexRsData,
    input  mipsPkg::wordT idexRtData,
    input  mipsPkg::wordT idexImm,
    input  mipsPkg::wordT idexBranchTarget,
    input  mipsPkg::regAddrT idexDst,
    input  mipsPkg::wordT wbData,
    input  mipsPkg::fwdSelT fwdA,
    input  mipsPkg::fwdSelT fwdB,
    input  mipsPkg::fwdSelT fwdStore,
    output logic branchTaken,
    output mipsPkg::wordT branchTarget,
    output mipsPkg::wordT exmemAluResult,
    output mipsPkg::wordT exmemStoreData,
    output mipsPkg::regAddrT exmemDst,
    output logic exmemRegWr,
    output logic exmemMemRd,
    output logic exmemMemWr,
    output logic exmemMemToReg,
    output logic exmemHalt
);
    import mipsPkg::*;

    wordT opA, rtFwd, opB, storeFwd, aluOut;

    function automatic wordT pick(fwdSelT sel, wordT regVal, wordT memVal, wordT wbVal);
        case (sel)
            fwdMem: return memVal;
            fwdWb: return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign opA = pick(fwdA, idexRsData, exmemAluResult, wbData);
    assign rtFwd = pick(fwdB, idexRtData, exmemAluResult, wbData);
    assign storeFwd = pick(fwdStore, idexRtData, exmemAluResult, wbData);
    // addi, lw and sw take the immediate
    assign opB = idexAluSrcImm ? idexImm : rtFwd;

    always_comb begin
        case (idexAluOp)
            aluSub: aluOut = opA - opB;
            aluAnd: aluOut = opA & opB;
            aluOr: aluOut = opA | opB;
            aluSlt: aluOut = {31'b0, $signed(opA) < $signed(opB)};
            default: aluOut = opA + opB;
        endcase
    end

    // compare uses the register value of rt, never the immediate
    assign branchTaken = (idexBranchEq && opA == rtFwd) || (idexBranchNe && opA != rtFwd);
    assign branchTarget = idexBranchTarget;

    always_ff @(posedge clk) begin
        if (!rstN || !run) begin
            exmemRegWr <= 1'b0;
            exmemMemRd <= 1'b0;
            exmemMemWr <= 1'b0;
            exmemMemToReg <= 1'b0;
            exmemHalt <= 1'b0;
        end else begin
            exmemRegWr <= idexRegWr;
            exmemMemRd <= idexMemRd;
            exmemMemWr <= idexMemWr;
            exmemMemToReg <= idexMemToReg;
            exmemHalt <= idexHalt;
        end
    end

    always_ff @(posedge clk) begin
        exmemAluResult <= aluOut;
        exmemStoreData <= storeFwd;
        exmemDst <= idexDst;
    end

endmodule

// ==== hdl/fetchStage.sv ====
//################################################
// program counter, instruction memory with a
// load port, IF/ID register
//################################################
`timescale 1ns/1ps

module fetchStage #(
    parameter int imemDepth = 256
) (
    input  logic clk,
    input  logic rstN,
    input  logic run,
    input  logic stall,
    input  logic halting,
    input  logic branchTaken,
    input  mipsPkg::wordT branchTarget,
    input  logic imemWr,
    input  logic [$clog2(imemDepth)-1:0] imemAddr,
    input  mipsPkg::wordT imemData,
    output mipsPkg::instrT ifidInstr,
    output mipsPkg::wordT ifidPcNext
);
    import mipsPkg::*;

    localparam int idxW = $clog2(imemDepth);

    wordT pc;
    wordT pcNext;
    wordT imem [imemDepth];

    assign pcNext = pc + 32'd4;

    // program load, accepted whether or not the core runs
    always_ff @(posedge clk) begin
        if (imemWr) begin
            imem[imemAddr] <= imemData;
        end
    end

    // taken branch wins over stall and halt
    always_ff @(posedge clk) begin
        if (!rstN || !run) begin
            pc <= '0;
        end else if (branchTaken) begin
            pc <= branchTarget;
        end else if (!stall && !halting) begin
            pc <= pcNext;
        end
    end

    // all-zero word decodes as a no-op
    always_ff @(posedge clk) begin
        if (!rstN || !run || branchTaken) begin
            ifidInstr <= '0;
        end else if (!stall) begin
            if (halting) begin
                ifidInstr <= '0;
            end else begin
                ifidInstr <= imem[pc[idxW+1:2]];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ifidPcNext <= pcNext;
        end
    end

endmodule

// ==== hdl/hazardUnit.sv ====
//################################################
// forwarding selects and load-use stall
//################################################
`timescale 1ns/1ps

module hazardUnit (
    input  mipsPkg::regAddrT idexRs,
    input  mipsPkg::regAddrT idexRt,
    input  mipsPkg::regAddrT ifidRs,
    input  mipsPkg::regAddrT ifidRt,
    input  mipsPkg::regAddrT exmemDst,
    input  mipsPkg::regAddrT wbAddr,
    input  logic idexMemRd,
    input  logic exmemRegWr,
    input  logic wbValid,
    output mipsPkg::fwdSelT fwdA,
    output mipsPkg::fwdSelT fwdB,
    output mipsPkg::fwdSelT fwdStore,
    output logic stall
);
    import mipsPkg::*;

    // EX/MEM holds the newer result, so it is checked first
    function automatic fwdSelT pick(regAddrT src, regAddrT memDst, logic memWr,
                                    regAddrT wbDst, logic wbWr);
        if (src != '0 && memWr && memDst == src) begin
            return fwdMem;
        end else if (src != '0 && wbWr && wbDst == src) begin
            return fwdWb;
        end
        return fwdNone;
    endfunction

    assign fwdA = pick(idexRs, exmemDst, exmemRegWr, wbAddr, wbValid);
    assign fwdB = pick(idexRt, exmemDst, exmemRegWr, wbAddr, wbValid);
    // store data takes the same rt path as operand B
    assign fwdStore = fwdB;

    // load result is not ready until it reaches MEM/WB
    assign stall = idexMemRd && (idexRt != '0) && (idexRt == ifidRs || idexRt == ifidRt);

endmodule

// ==== hdl/memoryStage.sv ====
//################################################
// data memory, MEM/WB register, writeback select
//################################################
`timescale 1ns/1ps

module memoryStage #(
    parameter int dmemDepth = 256
) (
    input  logic clk,
    input  logic rstN,
    input  logic run,
    input  logic exmemRegWr,
    input  logic exmemMemRd,
    input  logic exmemMemWr,
    input  logic exmemMemToReg,
    input  logic exmemHalt,
    input  mipsPkg::wordT exmemAluResult,
    input  mipsPkg::wordT exmemStoreData,
    input  mipsPkg::regAddrT exmemDst,
    output logic wbValid,
    output logic fin,
    output mipsPkg::regAddrT wbAddr,
    output mipsPkg::wordT wbData
);
    import mipsPkg::*;

    localparam int idxW = $clog2(dmemDepth);

    logic [idxW-1:0] dIdx;
    logic memwbRegWr, memwbMemToReg;
    wordT loadData, memwbAlu, memwbLoad;
    regAddrT memwbDst;
    wordT dmem [dmemDepth];

    // word index, byte offset bits dropped
    assign dIdx = exmemAluResult[idxW+1:2];
    assign loadData = exmemMemRd ? dmem[dIdx] : '0;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < dmemDepth; i++) begin
                dmem[i] <= '0;
            end
        end else if (exmemMemWr) begin
            dmem[dIdx] <= exmemStoreData;
        end
    end

    // fin stays up until run drops
    always_ff @(posedge clk) begin
        if (!rstN || !run) begin
            memwbRegWr <= 1'b0;
            memwbMemToReg <= 1'b0;
            fin <= 1'b0;
        end else begin
            memwbRegWr <= exmemRegWr;
            memwbMemToReg <= exmemMemToReg;
            if (exmemHalt) begin
                fin <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        memwbDst <= exmemDst;
        memwbAlu <= exmemAluResult;
        memwbLoad <= loadData;
    end

    assign wbValid = memwbRegWr && (memwbDst != '0);
    assign wbAddr = memwbDst;
    assign wbData = memwbMemToReg ? memwbLoad : memwbAlu;

endmodule

// ==== hdl/mipsPipeline.sv ====
//################################################
// five-stage pipeline top, stages and hazard unit
//################################################
`timescale 1ns/1ps

module mipsPipeline #(
    parameter int imemDepth = 256,
    parameter int dmemDepth = 256
) (
    input  logic clk,
    input  logic rstN,
    input  logic imemWr,
    input  logic [$clog2(imemDepth)-1:0] imemAddr,
    input  mipsPkg::wordT imemData,
    input  logic run,
    output logic wbValid,
    output mipsPkg::regAddrT wbAddr,
    output mipsPkg::wordT wbData,
    output logic fin
);
    import mipsPkg::*;

    logic stall, halting, branchTaken;
    wordT branchTarget;
    instrT ifidInstr;
    wordT ifidPcNext;

    logic idexRegWr, idexMemRd, idexMemWr, idexMemToReg;
    logic idexBranchEq, idexBranchNe, idexAluSrcImm, idexHalt;
    aluOpT idexAluOp;
    wordT idexRsData, idexRtData, idexImm, idexBranchTarget;
    regAddrT idexRs, idexRt, idexDst;

    fwdSelT fwdA, fwdB, fwdStore;

    logic exmemRegWr, exmemMemRd, exmemMemWr, exmemMemToReg, exmemHalt;
    wordT exmemAluResult, exmemStoreData;
    regAddrT exmemDst;

    fetchStage #(.imemDepth(imemDepth)) fetch (.*);

    decodeStage decode (.*);

    executeStage execute (.*);

    memoryStage #(.dmemDepth(dmemDepth)) memory (.*);

    hazardUnit hazard (
        .ifidRs(ifidInstr.r.rs),
        .ifidRt(ifidInstr.r.rt),
        .*
    );

endmodule

// ==== hdl/mipsPkg.sv ====
//################################################
// shared words, instruction views, ALU and
// forwarding encodings, opcode and funct codes
//################################################
package mipsPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0] regAddrT;

    typedef struct packed {
        logic [5:0] opcode;
        regAddrT rs;
        regAddrT rt;
        regAddrT rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFieldsT;

    typedef struct packed {
        logic [5:0] opcode;
        regAddrT rs;
        regAddrT rt;
        logic [15:0] imm16;
    } iFieldsT;

    // one instruction word, seen as R or I format
    typedef union packed {
        rFieldsT r;
        iFieldsT i;
    } instrT;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOpT;

    // operand source, newest result first
    typedef enum logic [1:0] {fwdNone, fwdMem, fwdWb} fwdSelT;

    localparam logic [5:0] opRtype = 6'h00;
    localparam logic [5:0] opAddi = 6'h08;
    localparam logic [5:0] opLw = 6'h23;
    localparam logic [5:0] opSw = 6'h2b;
    localparam logic [5:0] opBeq = 6'h04;
    localparam logic [5:0] opBne = 6'h05;
    localparam logic [5:0] opHalt = 6'h3f;

    localparam logic [5:0] fnAdd = 6'h20;
    localparam logic [5:0] fnSub = 6'h22;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr = 6'h25;
    localparam logic [5:0] fnSlt = 6'h2a;

endpackage

// ==== mipsPipeline.f ====
hdl/mipsPkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/hazardUnit.sv
hdl/mipsPipeline.sv
verification/mipsPipelineTb.sv

// ==== verification/mipsPipelineTb.sv ====
//################################################
// random programs, ISA reference model, writeback
// checks and per-test reporting for the pipeline
//################################################
`timescale 1ns/1ps

module mipsPipelineTb;
    import mipsPkg::*;

    logic clk;
    logic rstN;
    logic imemWr;
    logic [7:0] imemAddr;
    wordT imemData;
    logic run;
    logic wbValid;
    regAddrT wbAddr;
    wordT wbData;
    logic fin;

    logic [31:0] lfsr;
    wordT prog [256];
    int progLen;
    regAddrT expRegQ [$];
    wordT expValQ [$];
    int errCount;
    int checks;
    int failedTests;
    logic timedOut;

    mipsPipeline #(.imemDepth(256), .dmemDepth(256)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic wordT encR(logic [5:0] fn, regAddrT rs, regAddrT rt, regAddrT rd);
        return {opRtype, rs, rt, rd, 5'b0, fn};
    endfunction

    function automatic wordT encI(logic [5:0] op, regAddrT rs, regAddrT rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [5:0] pickFunct(input int n);
        case (n % 5)
            0: return fnAdd;
            1: return fnSub;
            2: return fnAnd;
            3: return fnOr;
            default: return fnSlt;
        endcase
    endfunction

    function automatic string kindName(input int kind);
        case (kind)
            0: return "independent ALU";
            1: return "dependent ALU";
            2: return "load and store";
            3: return "branches";
            default: return "halt and r0";
        endcase
    endfunction

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        checks++;
        if (got !== exp) begin
            $display("Error at %0t ns: %s got %h, expected %h", $time, name, got, exp);
            errCount++;
        end
    endtask

    task automatic checkReg(input string name, input regAddrT got, input regAddrT exp);
        checks++;
        if (got !== exp) begin
            $display("Error at %0t ns: %s got %0d, expected %0d", $time, name, got, exp);
            errCount++;
        end
    endtask

    task automatic genProgram(input int kind, input int len);
        int sel;
        int off;
        regAddrT rs, rt, rd;
        logic [15:0] imm;
        logic [5:0] fn;
        logic [2:0] slot;
        logic loadPrev;
        regAddrT loadReg;
        regAddrT hist [3];
        for (int k = 0; k < 3; k++) begin
            hist[k] = '0;
        end
        loadPrev = 1'b0;
        loadReg = '0;
        for (int i = 0; i < len; i++) begin
            rs = 5'(takeBits(3));
            rt = 5'(takeBits(3));
            rd = 5'(takeBits(3)) + 5'd1;
            if (kind == 0) begin
                // keep sources clear of the last three results
                if (rs == hist[0] || rs == hist[1] || rs == hist[2]) begin
                    rs = '0;
                end
                if (rt == hist[0] || rt == hist[1] || rt == hist[2]) begin
                    rt = '0;
                end
            end else if (kind == 1) begin
                rs = hist[0];
                rt = hist[1];
            end
            if (kind == 4 && takeBits(2) == 0) begin
                rd = '0;
            end
            imm = 16'(takeBits(16));
            fn = pickFunct(int'(takeBits(3)));
            slot = 3'(takeBits(3));
            sel = int'(takeBits(2));
            hist[2] = hist[1];
            hist[1] = hist[0];
            hist[0] = rd;
            if (loadPrev) begin
                // use the loaded register right away
                prog[i] = encR(fn, loadReg, rt, rd);
                loadPrev = 1'b0;
            end else if (kind == 2 && sel == 1) begin
                prog[i] = encI(opSw, '0, rt, {11'b0, slot, 2'b0});
                hist[0] = '0;
            end else if (kind == 2 && sel == 2) begin
                prog[i] = encI(opLw, '0, rd, {11'b0, slot, 2'b0});
                loadPrev = 1'b1;
                loadReg = rd;
            end else if (kind == 3 && sel == 0) begin
                // forward only, never past the halt
                off = int'(takeBits(2));
                if (i + 1 + off > len) begin
                    off = len - 1 - i;
                end
                rs = 5'(takeBits(2));
                rt = 5'(takeBits(2));
                prog[i] = encI(takeBits(1) ? opBne : opBeq, rs, rt, 16'(off));
                hist[0] = '0;
            end else if (sel == 3) begin
                prog[i] = encR(fn, rs, rt, rd);
            end else begin
                prog[i] = encI(opAddi, rs, rd, imm);
            end
        end
        prog[len] = {opHalt, 26'b0};
        progLen = len + 1;
        if (kind == 4) begin
            // live writes placed behind the halt
            for (int k = 1; k <= 3; k++) begin
                prog[len + k] = encI(opAddi, '0, 5'(k), 16'h0055);
            end
            progLen = len + 4;
        end
    endtask

    task automatic runModel();
        wordT regs [32];
        wordT mem [256];
        wordT w, a, b, v, imm, addr;
        regAddrT dst;
        logic wr;
        logic done;
        int pc;
        expRegQ.delete();
        expValQ.delete();
        for (int k = 0; k < 32; k++) begin
            regs[k] = '0;
        end
        for (int k = 0; k < 256; k++) begin
            mem[k] = '0;
        end
        pc = 0;
        done = 1'b0;
        while (!done && pc < progLen) begin
            w = prog[pc];
            a = regs[w[25:21]];
            b = regs[w[20:16]];
            imm = {{16{w[15]}}, w[15:0]};
            addr = a + imm;
            dst = w[20:16];
            wr = 1'b0;
            v = '0;
            pc++;
            case (w[31:26])
                opRtype: begin
                    wr = 1'b1;
                    dst = w[15:11];
                    case (w[5:0])
                        fnAdd: v = a + b;
                        fnSub: v = a - b;
                        fnAnd: v = a & b;
                        fnOr: v = a | b;
                        fnSlt: v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                opAddi: begin
                    wr = 1'b1;
                    v = a + imm;
                end
                opLw: begin
                    wr = 1'b1;
                    v = mem[addr[9:2]];
                end
                opSw: mem[addr[9:2]] = b;
                opBeq: pc = (a == b) ? pc + int'($signed(imm)) : pc;
                opBne: pc = (a != b) ? pc + int'($signed(imm)) : pc;
                opHalt: done = 1'b1;
                default: ;
            endcase
            if (wr && dst != '0) begin
                regs[dst] = v;
                expRegQ.push_back(dst);
                expValQ.push_back(v);
            end
        end
    endtask

    task automatic runTest(input int testNum, input int kind, input int len);
        int cycles;
        int limit;
        int writes;
        int errsBefore;
        logic done;
        genProgram(kind, len);
        runModel();
        errsBefore = errCount;
        @(posedge clk);
        rstN <= 1'b0;
        run <= 1'b0;
        repeat (10) @(posedge clk);
        rstN <= 1'b1;
        // trailing no-ops cover the fetch past the halt
        for (int a = 0; a < progLen + 4; a++) begin
            @(posedge clk);
            imemWr <= 1'b1;
            imemAddr <= 8'(a);
            imemData <= (a < progLen) ? prog[a] : '0;
        end
        @(posedge clk);
        imemWr <= 1'b0;
        run <= 1'b1;
        limit = 20 * progLen + 100;
        cycles = 0;
        writes = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (wbValid) begin
                if (expRegQ.size() == 0) begin
                    $display("write to r%0d at %0t ns goes beyond the expected writes",
                             wbAddr, $time);
                    errCount++;
                end else begin
                    checkReg("wbAddr", wbAddr, expRegQ.pop_front());
                    checkWord("wbData", wbData, expValQ.pop_front());
                    writes++;
                end
            end
            if (fin) begin
                done = 1'b1;
            end else if (cycles >= limit) begin
                $display("fin did not rise within %0d cycles", limit);
                timedOut = 1'b1;
                done = 1'b1;
            end
        end
        if (!timedOut) begin
            repeat (8) begin
                @(negedge clk);
                if (wbValid) begin
                    $display("write to r%0d at %0t ns came after fin", wbAddr, $time);
                    errCount++;
                end
            end
            if (expRegQ.size() != 0) begin
                $display("fin rose with %0d expected writes still missing", expRegQ.size());
                errCount++;
            end
        end
        @(posedge clk);
        run <= 1'b0;
        if (errCount != errsBefore || timedOut) begin
            failedTests++;
        end
        $display("test %0d (%s): %0d writes in %0d cycles, %s", testNum, kindName(kind),
                 writes, cycles, (errCount == errsBefore && !timedOut) ? "ok" : "failed");
    endtask

    initial begin
        rstN <= 1'b0;
        run <= 1'b0;
        imemWr <= 1'b0;
        imemAddr <= '0;
        imemData <= '0;
        lfsr = 32'h200b;
        errCount = 0;
        checks = 0;
        failedTests = 0;
        timedOut = 1'b0;
        for (int t = 0; t < 10 && !timedOut; t++) begin
            runTest(t, t % 5, (t < 5) ? 24 : 40);
        end
        $display("%0d failed tests, %0d checks, %0d errors", failedTests, checks, errCount);
        if (errCount == 0 && failedTests == 0 && !timedOut) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
